// ==== mm_pkg.sv ====
/*
  Shared types and constants for the chip bus system.
  CPU addresses are word addresses (byte bits 23..1), chip-bus addresses are 20 bits.
  Struct field order is fixed; testbench and RTL pack requests the same way.
*/
`default_nettype none

package mm_pkg;

	// ------------------------------
	// widths that carry a meaning
	// ------------------------------
	typedef logic [15:0] word_t;       // data word
	typedef logic [22:0] cpu_addr_t;   // cpu word address, byte bits 23..1
	typedef logic [19:0] chip_addr_t;  // chip bus word address
	typedef logic [63:0] rtc_t;        // 16 nibbles of clock value

	localparam int LED_CNT_W = 6;      // led dimmer counter
	typedef logic [LED_CNT_W-1:0] led_cnt_t;

	// ------------------------------
	// address map
	// ------------------------------
	localparam logic [7:0] RTC_BASE = 8'hDC;  // top byte of rtc area

	// first word above chip area, i.e. byte bits 23..21 zero below it
	localparam cpu_addr_t CHIP_TOP = 23'h10_0000;

	typedef enum logic [1:0] {
		REGION_NONE,
		REGION_CHIP,
		REGION_RTC
	} region_t;

	// ------------------------------
	// bus requests and commands
	// ------------------------------
	typedef struct packed {
		logic      valid;  // level, held until ack
		logic      rd;
		logic      hwr;    // upper byte write
		logic      lwr;    // lower byte write
		cpu_addr_t addr;
		word_t     wdata;
	} cpu_req_t;

	typedef struct packed {
		logic       valid;  // one-cycle strobe
		logic       wr;     // always both bytes
		chip_addr_t addr;
		word_t      wdata;
	} dma_req_t;

	// command from arbiter to all peers
	typedef struct packed {
		logic       rd;
		logic       hwr;
		logic       lwr;
		chip_addr_t addr;
		word_t      wdata;
	} bus_cmd_t;

	// ------------------------------
	// reset sequencer states
	// ------------------------------
	typedef enum logic [1:0] {
		RST_HOLD,   // external reset active
		RST_COUNT,  // counting frame pulses
		RST_RUN     // system released
	} rst_state_t;

endpackage

`default_nettype wire

// ==== mm_bus_arbiter.sv ====
/*
  Chip bus arbiter, DMA always first and never stalled.
  CPU request is a held level, acknowledged one cycle after its grant.
  Unmapped CPU accesses are acknowledged, reads give zero, writes are lost.
  Peers must drive zero rdata unless they served a read the cycle before.
*/
`default_nettype none

module mm_bus_arbiter import mm_pkg::*; #(
	parameter int CHIP_AW = 10
) (
	input  wire logic     clk,
	input  wire logic     rst_n,
	input  wire cpu_req_t cpu_req,
	input  wire dma_req_t dma_req,
	output bus_cmd_t      cmd,
	output logic          sel_chip,
	output logic          sel_rtc,
	input  wire word_t    chip_rdata,
	input  wire word_t    rtc_rdata,
	output logic          cpu_ack,
	output logic          dbr,
	output word_t         cpu_rdata,
	output word_t         dma_rdata
);

	// mirror mask for chip ram
	localparam chip_addr_t CHIP_MASK = chip_addr_t'((1 << CHIP_AW) - 1);

	region_t cpu_region;
	logic    cpu_go;      // cpu owns the bus this cycle
	logic    grant_q;     // cpu granted last cycle, ack now
	logic    dma_rd_q;    // dma read issued last cycle
	word_t   rdata_or;

	// ------------------------------
	// address decode
	// ------------------------------
	always_comb begin
		if (cpu_req.addr < CHIP_TOP)
			cpu_region = REGION_CHIP;
		else if (cpu_req.addr[22:15] == RTC_BASE)  // byte bits 23..16
			cpu_region = REGION_RTC;
		else
			cpu_region = REGION_NONE;
	end

	// ------------------------------
	// ownership, dma first
	// ------------------------------
	assign dbr    = dma_req.valid;  // data bus request while dma holds the bus
	assign cpu_go = cpu_req.valid && !dma_req.valid && !grant_q;  // no regrant during ack

	always_comb begin
		cmd      = '0;
		sel_chip = 1'b0;
		sel_rtc  = 1'b0;
		if (dma_req.valid) begin
			cmd.rd    = !dma_req.wr;
			cmd.hwr   = dma_req.wr;  // dma writes whole words
			cmd.lwr   = dma_req.wr;
			cmd.addr  = dma_req.addr & CHIP_MASK;
			cmd.wdata = dma_req.wdata;
			sel_chip  = 1'b1;        // dma only ever sees chip ram
		end else if (cpu_go) begin
			cmd.rd    = cpu_req.rd;
			cmd.hwr   = cpu_req.hwr;
			cmd.lwr   = cpu_req.lwr;
			cmd.wdata = cpu_req.wdata;
			cmd.addr  = cpu_req.addr[19:0] & CHIP_MASK;  // mirrored, rtc bits 4..1 kept
			sel_chip = (cpu_region == REGION_CHIP);
			sel_rtc  = (cpu_region == REGION_RTC);
			// REGION_NONE selects nobody, write dropped, read gives zero
		end
	end

	// ------------------------------
	// owner registers
	// ------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			grant_q  <= 1'b0;
			dma_rd_q <= 1'b0;
		end else begin
			grant_q  <= cpu_go;
			dma_rd_q <= dma_req.valid && !dma_req.wr;
		end
	end

	// ------------------------------
	// read data return
	// ------------------------------
	assign rdata_or  = chip_rdata | rtc_rdata;  // idle peers drive zero
	assign cpu_ack   = grant_q;                 // one cycle after grant
	assign cpu_rdata = grant_q ? rdata_or : '0;
	assign dma_rdata = dma_rd_q ? rdata_or : '0;

endmodule

`default_nettype wire

// ==== mm_chip_ram.sv ====
/*
  Chip RAM, 2**CHIP_AW words with separate byte-lane writes.
  Read data is registered and appears one cycle after a selected read.
  Contents are not initialised.
*/
`default_nettype none

module mm_chip_ram import mm_pkg::*; #(
	parameter int CHIP_AW = 10
) (
	input  wire logic     clk,
	input  wire logic     sel,
	input  wire bus_cmd_t cmd,
	output word_t         rdata
);

	localparam int DEPTH = 1 << CHIP_AW;

	word_t              mem [DEPTH];
	logic [CHIP_AW-1:0] waddr;  // wrapped word address

	assign waddr = cmd.addr[CHIP_AW-1:0];  // higher bits mirror

	// ------------------------------
	// byte lane writes
	// ------------------------------
	always_ff @(posedge clk) begin
		if (sel && cmd.hwr)
			mem[waddr][15:8] <= cmd.wdata[15:8];  // upper byte
		if (sel && cmd.lwr)
			mem[waddr][7:0] <= cmd.wdata[7:0];    // lower byte
	end

	// registered read, zero when idle so it can be ORed
	always_ff @(posedge clk) begin
		if (sel && cmd.rd)
			rdata <= mem[waddr];
		else
			rdata <= '0;
	end

endmodule

`default_nettype wire

// ==== mm_rtc_port.sv ====
/*
  Read-only real-time-clock port.
  Word address bits 4..1 (byte bits 5..2) pick one nibble, zero-extended.
  Writes are ignored.
*/
`default_nettype none

module mm_rtc_port import mm_pkg::*; (
	input  wire logic     clk,
	input  wire logic     rst_n,
	input  wire logic     sel,
	input  wire bus_cmd_t cmd,
	input  wire rtc_t     rtc,
	output word_t         rdata
);

	logic [3:0] nib_idx;  // which of 16 nibbles
	logic [3:0] nibble;

	assign nib_idx = cmd.addr[4:1];
	assign nibble  = rtc[{nib_idx, 2'b00} +: 4];

	always_ff @(posedge clk) begin
		if (!rst_n)
			rdata <= '0;
		else if (sel && cmd.rd)
			rdata <= {12'h000, nibble};  // zero-extended
		else
			rdata <= '0;                 // idle, keeps the OR clean
	end

endmodule

`default_nettype wire

// ==== mm_syscontrol.sv ====
/*
  System reset sequencer and PAL/NTSC latch.
  After rst_ext falls, reset holds for RST_FRAMES sof pulses (RST_FRAMES >= 1).
  A sof in the cycle leaving RST_HOLD is not counted.
  The video-mode latch only follows ntsc_cfg while rst_out is high.
*/
`default_nettype none

module mm_syscontrol import mm_pkg::*; #(
	parameter int       RST_FRAMES = 4,
	parameter bit       NTSC       = 1'b0
) (
	input  wire logic clk,
	input  wire logic rst_n,
	input  wire logic rst_ext,
	input  wire logic sof,
	input  wire logic cpu_reset_in,  // active low
	input  wire logic ntsc_cfg,
	output logic      sys_reset,
	output logic      rst_out,
	output logic      ntsc
);

	localparam int CNT_W = $clog2(RST_FRAMES + 1);
	localparam logic [CNT_W-1:0] LAST_FRAME = CNT_W'(RST_FRAMES - 1);

	rst_state_t       state;
	logic [CNT_W-1:0] frame_cnt;  // sof pulses seen in RST_COUNT

	// ------------------------------
	// reset sequencer
	// ------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state     <= RST_HOLD;
			frame_cnt <= '0;
		end else if (rst_ext) begin
			state     <= RST_HOLD;  // external reset wins in any state
			frame_cnt <= '0;
		end else begin
			case (state)
				RST_HOLD: begin
					state     <= RST_COUNT;
					frame_cnt <= '0;
				end
				RST_COUNT: begin
					if (sof) begin
						if (frame_cnt == LAST_FRAME)
							state <= RST_RUN;  // last frame seen
						else
							frame_cnt <= frame_cnt + 1'b1;
					end
				end
				RST_RUN: ;  // stays until rst_ext or rst_n
				default: state <= RST_HOLD;
			endcase
		end
	end

	assign sys_reset = (state != RST_RUN);
	assign rst_out   = sys_reset || !cpu_reset_in;  // cpu side can hold reset too

	// ------------------------------
	// video mode latch
	// ------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n)
			ntsc <= NTSC;
		else if (rst_out)
			ntsc <= ntsc_cfg;  // mode change only takes effect through reset
	end

endmodule

`default_nettype wire

// ==== mm_top.sv ====
/*
  Chipset glue top level: arbiter, chip RAM, RTC port and system control.
  All logic runs on every clk edge; rst_n is the synchronous power-on reset.
  cpu_reset is active low and only follows the internal sequencer.
  CHIP_AW must be at least 5 so RTC nibble bits pass the chip mask untouched.
*/
`default_nettype none

module mm_top import mm_pkg::*; #(
	parameter int CHIP_AW    = 10,
	parameter int RST_FRAMES = 4,
	parameter bit NTSC       = 1'b0
) (
	input  wire logic     clk,
	input  wire logic     rst_n,
	input  wire cpu_req_t cpu_req,
	output logic          cpu_ack,
	output word_t         cpu_rdata,
	input  wire dma_req_t dma_req,
	output word_t         dma_rdata,
	output logic          dbr,
	input  wire rtc_t     rtc,
	input  wire logic     sof,
	input  wire logic     rst_ext,
	input  wire logic     cpu_reset_in,  // active low
	input  wire logic     ntsc_cfg,
	input  wire logic     led_n,         // led off request, active low
	output logic          rst_out,
	output logic          cpu_reset,     // active low
	output logic          ntsc,
	output logic          pwr_led
);

	// shared chip bus
	bus_cmd_t cmd;
	logic     sel_chip;
	logic     sel_rtc;
	word_t    chip_rdata;
	word_t    rtc_rdata;

	logic     sys_reset;   // sequencer only, without cpu reset input
	led_cnt_t led_cnt;
	logic     led_dim;

	// ------------------------------
	// bus arbitration
	// ------------------------------
	mm_bus_arbiter #(
		.CHIP_AW (CHIP_AW)
	) u_arbiter (
		.clk        (clk),
		.rst_n      (rst_n),
		.cpu_req    (cpu_req),
		.dma_req    (dma_req),
		.cmd        (cmd),
		.sel_chip   (sel_chip),
		.sel_rtc    (sel_rtc),
		.chip_rdata (chip_rdata),
		.rtc_rdata  (rtc_rdata),
		.cpu_ack    (cpu_ack),
		.dbr        (dbr),
		.cpu_rdata  (cpu_rdata),
		.dma_rdata  (dma_rdata)
	);

	// ------------------------------
	// bus peers
	// ------------------------------
	mm_chip_ram #(
		.CHIP_AW (CHIP_AW)
	) u_chip_ram (
		.clk   (clk),
		.sel   (sel_chip),
		.cmd   (cmd),
		.rdata (chip_rdata)
	);

	mm_rtc_port u_rtc_port (
		.clk   (clk),
		.rst_n (rst_n),
		.sel   (sel_rtc),
		.cmd   (cmd),
		.rtc   (rtc),
		.rdata (rtc_rdata)
	);

	// ------------------------------
	// reset and video mode
	// ------------------------------
	mm_syscontrol #(
		.RST_FRAMES (RST_FRAMES),
		.NTSC       (NTSC)
	) u_syscontrol (
		.clk          (clk),
		.rst_n        (rst_n),
		.rst_ext      (rst_ext),
		.sof          (sof),
		.cpu_reset_in (cpu_reset_in),
		.ntsc_cfg     (ntsc_cfg),
		.sys_reset    (sys_reset),
		.rst_out      (rst_out),
		.ntsc         (ntsc)
	);

	assign cpu_reset = !sys_reset;  // cpu held while sequencer runs

	// ------------------------------
	// power led dimmer
	// ------------------------------
	// led lit 4 cycles in 64 when dimmed
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			led_cnt <= '0;
			led_dim <= 1'b0;
		end else begin
			led_cnt <= led_cnt + 1'b1;              // free running
			led_dim <= |led_cnt[LED_CNT_W-1:2];
		end
	end

	assign pwr_led = !(led_n && led_dim);  // full on when led_n low

endmodule

`default_nettype wire

// ==== tb_mm_top.sv ====
/*
  Testbench for mm_top with CHIP_AW 6 and RST_FRAMES 3.
  Chip RAM is filled by DMA first, since its contents start unknown.
  Random stimulus comes from a fixed-seed xorshift generator.
*/
`default_nettype none

module tb_mm_top import mm_pkg::*; ();

	localparam int FRAMES      = 3;   // matches RST_FRAMES of the DUT
	localparam int ACK_TIMEOUT = 40;  // cycles to wait for cpu_ack

	logic     clk;
	logic     rst_n;
	cpu_req_t cpu_req;
	dma_req_t dma_req;
	rtc_t     rtc_val;
	logic     sof;
	logic     rst_ext;
	logic     cpu_reset_in;
	logic     ntsc_cfg;
	logic     led_n;
	logic     cpu_ack;
	word_t    cpu_rdata;
	word_t    dma_rdata;
	logic     dbr;
	logic     rst_out;
	logic     cpu_reset;
	logic     ntsc;
	logic     pwr_led;

	word_t       model_mem [64];     // reference copy of chip ram
	logic [31:0] rng_state = 32'd74;
	int          errors    = 0;
	int          timeouts  = 0;

	mm_top #(
		.CHIP_AW    (6),
		.RST_FRAMES (FRAMES),
		.NTSC       (1'b0)
	) UUT (
		.clk          (clk),
		.rst_n        (rst_n),
		.cpu_req      (cpu_req),
		.cpu_ack      (cpu_ack),
		.cpu_rdata    (cpu_rdata),
		.dma_req      (dma_req),
		.dma_rdata    (dma_rdata),
		.dbr          (dbr),
		.rtc          (rtc_val),
		.sof          (sof),
		.rst_ext      (rst_ext),
		.cpu_reset_in (cpu_reset_in),
		.ntsc_cfg     (ntsc_cfg),
		.led_n        (led_n),
		.rst_out      (rst_out),
		.cpu_reset    (cpu_reset),
		.ntsc         (ntsc),
		.pwr_led      (pwr_led)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ------------------------------
	// helpers
	// ------------------------------
	function automatic logic [31:0] next_rand();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	task automatic check_val(input string what, input logic [63:0] got, input logic [63:0] exp);
		assert (got === exp)
		else begin
			errors++;
			$display("CHECK FAILED at %0t: %s expected %0h, got %0h", $time, what, exp, got);
		end
	endtask

	// expected cpu read word, straight from the address map
	function automatic word_t cpu_expect(input cpu_addr_t a);
		if (a[22:20] == 3'b000)
			return model_mem[a[5:0]];  // chip ram, mirrored every 64 words
		if (a[22:15] == RTC_BASE)
			return {12'h000, rtc_val[int'(a[4:1]) * 4 +: 4]};
		return 16'h0000;               // unmapped
	endfunction

	function automatic cpu_addr_t unmapped_addr(input logic [31:0] r);
		cpu_addr_t a;
		a = r[22:0];
		if (a[22:20] == 3'b000)
			a[22] = 1'b1;              // leave chip area
		if (a[22:15] == RTC_BASE)
			a[15] = ~a[15];            // leave rtc area
		return a;
	endfunction

	// waits for the ack of the held cpu request, then drops it
	task automatic wait_ack(input word_t exp);
		int n;
		n = 0;
		@(negedge clk);
		while (!cpu_ack && n < ACK_TIMEOUT) begin
			n++;
			@(negedge clk);
		end
		if (cpu_ack)
			check_val("cpu_rdata", cpu_rdata, exp);
		else begin
			timeouts++;
			$display("timeout at %0t: cpu_ack did not arrive within %0d cycles", $time, ACK_TIMEOUT);
		end
		@(posedge clk);
		cpu_req <= '0;
	endtask

	task automatic cpu_access(input logic rd, input logic hwr, input logic lwr,
			input cpu_addr_t a, input word_t wd);
		cpu_req_t r;
		word_t    exp;
		r       = '0;
		r.valid = 1'b1;
		r.rd    = rd;
		r.hwr   = hwr;
		r.lwr   = lwr;
		r.addr  = a;
		r.wdata = wd;
		exp     = rd ? cpu_expect(a) : 16'h0000;  // writes return zero
		if (!rd && a[22:20] == 3'b000) begin
			if (hwr)
				model_mem[a[5:0]][15:8] = wd[15:8];
			if (lwr)
				model_mem[a[5:0]][7:0] = wd[7:0];
		end
		@(posedge clk);
		cpu_req <= r;
		wait_ack(exp);
	endtask

	// whole ram by dma, pattern depends on all address bits
	task automatic fill_ram();
		dma_req_t d;
		for (int i = 0; i < 64; i++) begin
			d          = '0;
			d.valid    = 1'b1;
			d.wr       = 1'b1;
			d.addr     = 20'(i);
			d.wdata    = word_t'(i * 16'h0325) ^ 16'hA55A;
			model_mem[i] = d.wdata;
			@(posedge clk);
			dma_req <= d;
		end
		@(posedge clk);
		dma_req <= '0;
	endtask

	// dma strobes every cycle, cpu read raised with the first strobe
	task automatic dma_burst(input int len, input cpu_addr_t cpu_a);
		dma_req_t    d;
		cpu_req_t    c;
		word_t       exp_dma;
		logic [31:0] r;
		logic [31:0] r2;
		c       = '0;
		c.valid = 1'b1;
		c.rd    = 1'b1;
		c.addr  = cpu_a;
		exp_dma = 16'h0000;
		for (int i = 0; i < len; i++) begin
			r       = next_rand();
			r2      = next_rand();
			d       = '0;
			d.valid = 1'b1;
			d.wr    = r[0];
			d.addr  = r2[19:0];
			d.wdata = r[31:16];
			@(posedge clk);
			dma_req <= d;
			if (i == 0)
				cpu_req <= c;
			@(negedge clk);
			check_val("dbr", dbr, 1'b1);
			check_val("cpu_ack", cpu_ack, 1'b0);       // cpu held off
			check_val("dma_rdata", dma_rdata, exp_dma);  // read of the cycle before
			exp_dma = d.wr ? 16'h0000 : model_mem[d.addr[5:0]];
			if (d.wr)
				model_mem[d.addr[5:0]] = d.wdata;
		end
		@(posedge clk);
		dma_req <= '0;
		@(negedge clk);
		check_val("dma_rdata", dma_rdata, exp_dma);
		check_val("dbr", dbr, 1'b0);
		wait_ack(cpu_expect(cpu_a));  // pending cpu read now completes
	endtask

	// ------------------------------
	// stimulus
	// ------------------------------
	initial begin
		logic [31:0] r;
		logic [31:0] r2;
		logic        v_prev;
		int          lit;
		rst_n        = 1'b0;
		cpu_req      = '0;
		dma_req      = '0;
		rtc_val      = {next_rand(), next_rand()};
		sof          = 1'b0;
		rst_ext      = 1'b0;
		cpu_reset_in = 1'b1;
		ntsc_cfg     = 1'b0;
		led_n        = 1'b1;

		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_val("rst_out", rst_out, 1'b1);
		check_val("cpu_ack", cpu_ack, 1'b0);
		check_val("dbr", dbr, 1'b0);
		check_val("cpu_rdata", cpu_rdata, 16'h0000);
		check_val("dma_rdata", dma_rdata, 16'h0000);
		check_val("ntsc", ntsc, 1'b0);

		// two frames counted first, the external reset must discard them
		repeat (2) begin
			@(posedge clk);
			sof <= 1'b1;
			@(posedge clk);
			sof <= 1'b0;
			@(negedge clk);
			check_val("rst_out", rst_out, 1'b1);
		end

		// external reset pulse, then FRAMES sof pulses
		@(posedge clk);
		rst_ext <= 1'b1;
		repeat (3) @(posedge clk);
		rst_ext <= 1'b0;
		for (int k = 1; k <= FRAMES; k++) begin
			repeat (3) begin
				@(posedge clk);
				@(negedge clk);
				check_val("rst_out", rst_out, 1'b1);
				check_val("cpu_reset", cpu_reset, 1'b0);
			end
			@(posedge clk);
			sof <= 1'b1;
			@(posedge clk);
			sof <= 1'b0;
			@(negedge clk);
			check_val("rst_out", rst_out, k < FRAMES);
			check_val("cpu_reset", cpu_reset, k == FRAMES);
		end

		// cpu reset input holds rst_out, ntsc follows cfg meanwhile
		@(posedge clk);
		cpu_reset_in <= 1'b0;
		v_prev = ntsc_cfg;
		repeat (8) begin
			r = next_rand();
			@(posedge clk);
			ntsc_cfg <= r[0];
			@(negedge clk);
			check_val("rst_out", rst_out, 1'b1);
			check_val("cpu_reset", cpu_reset, 1'b1);  // sequencer already released
			check_val("ntsc", ntsc, v_prev);
			v_prev = r[0];
		end
		@(posedge clk);
		cpu_reset_in <= 1'b1;  // last load of ntsc at this edge
		repeat (8) begin
			r = next_rand();
			@(posedge clk);
			ntsc_cfg <= r[0];
			@(negedge clk);
			check_val("rst_out", rst_out, 1'b0);
			check_val("ntsc", ntsc, v_prev);  // held
		end

		// power led dimming
		lit = 0;
		repeat (64) begin
			@(negedge clk);
			if (pwr_led)
				lit++;
		end
		check_val("pwr_led lit cycles", lit, 4);
		@(posedge clk);
		led_n <= 1'b0;
		lit = 0;
		repeat (64) begin
			@(negedge clk);
			if (pwr_led)
				lit++;
		end
		check_val("pwr_led lit cycles", lit, 64);
		@(posedge clk);
		led_n <= 1'b1;

		// cpu chip ram access with byte lanes and mirrors
		fill_ram();
		repeat (40) begin
			r  = next_rand();
			r2 = next_rand();
			cpu_access(1'b0, r[0], r[1], {3'b000, r2[19:0]}, r[31:16]);
		end
		repeat (40) begin
			r = next_rand();
			cpu_access(1'b1, 1'b0, 1'b0, {3'b000, r[19:0]}, 16'h0000);
		end

		// dma priority over a waiting cpu read
		repeat (3) begin
			r  = next_rand();
			r2 = next_rand();
			dma_burst(8 + int'(r[3:0]), {3'b000, r2[19:0]});
		end

		// rtc reads, dropped writes, unmapped reads
		repeat (20) begin
			r = next_rand();
			cpu_access(1'b1, 1'b0, 1'b0, {RTC_BASE, r[14:0]}, 16'h0000);
		end
		repeat (20) begin
			r  = next_rand();
			r2 = next_rand();
			if (r[0])
				cpu_access(1'b0, 1'b1, 1'b1, {RTC_BASE, r2[14:0]}, r[31:16]);
			else
				cpu_access(1'b0, 1'b1, 1'b1, unmapped_addr(r2), r[31:16]);
		end
		repeat (10) begin
			r = next_rand();
			cpu_access(1'b1, 1'b0, 1'b0, unmapped_addr(r), 16'h0000);
		end
		for (int i = 0; i < 64; i++) begin
			r = next_rand();
			cpu_access(1'b1, 1'b0, 1'b0, {3'b000, r[19:6], 6'(i)}, 16'h0000);
		end

		$display("errors: %0d check failures, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
mm_pkg.sv
mm_bus_arbiter.sv
mm_chip_ram.sv
mm_rtc_port.sv
mm_syscontrol.sv
mm_top.sv
tb_mm_top.sv
